// ==== compile.f ====
+incdir+tests
hdl/arm_core_pkg.sv
hdl/control_unit.sv
hdl/alu.sv
hdl/execute_stage.sv
hdl/register_file.sv
hdl/result_stage.sv
hdl/arm_exec_core.sv
tests/tb_arm_exec_core.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 --top-module tb_arm_exec_core -f compile.f -o tb_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/tb_sim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulator exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "Simulation completed successfully"; then
    exit 0
fi
exit 1

// ==== tests/tb_ref_model.svh ====
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

logic [31:0] m_regs [16];
logic [7:0]  m_mem  [2**DMEM_AW];
logic [3:0]  m_flags;                    // {n, z, c, v}
logic [31:0] m_pc;

task automatic model_reset();
    for (int i = 0; i < 16; i++) begin
        m_regs[i] = '0;
    end
    for (int i = 0; i < 2**DMEM_AW; i++) begin
        m_mem[i] = '0;
    end
    m_flags = '0;
    m_pc    = '0;
endtask

// ARM condition rules on n, z, c, v
function automatic logic cond_holds(logic [3:0] cond, logic [3:0] f);
    logic n;
    logic z;
    logic c;
    logic v;
    n = f[3];
    z = f[2];
    c = f[1];
    v = f[0];
    case (cond)
        4'h0: return z;
        4'h1: return !z;
        4'h2: return c;
        4'h3: return !c;
        4'h4: return n;
        4'h5: return !n;
        4'h6: return v;
        4'h7: return !v;
        4'h8: return c && !z;
        4'h9: return !c || z;
        4'hA: return n == v;
        4'hB: return n != v;
        4'hC: return !z && (n == v);
        4'hD: return z || (n != v);
        4'hE: return 1'b1;
        default: return 1'b0;            // Never
    endcase
endfunction

// Data-processing result and the flags it would set
task automatic alu_model(input logic [3:0] opc, input logic [31:0] a, input logic [31:0] b,
                         input logic [3:0] f_in, output logic [31:0] r,
                         output logic [3:0] f_out);
    logic [32:0] s;
    logic [31:0] x;
    logic [31:0] y;
    logic        ci;
    logic        arith;
    arith = 1'b1;
    x     = a;
    y     = b;
    ci    = 1'b0;
    r     = '0;
    case (opc)
        4'h2, 4'hA: begin y = ~b; ci = 1'b1; end           // a - b
        4'h3: begin x = b; y = ~a; ci = 1'b1; end           // b - a
        4'h4, 4'hB: ci = 1'b0;                              // a + b
        4'h5: ci = f_in[1];
        4'h6: begin y = ~b; ci = !f_in[1]; end              // a - b - c
        4'h7: begin x = b; y = ~a; ci = !f_in[1]; end
        default: arith = 1'b0;
    endcase
    s = {1'b0, x} + {1'b0, y} + {32'd0, ci};
    case (opc)
        4'h0, 4'h8: r = a & b;
        4'h1, 4'h9: r = a ^ b;
        4'hC: r = a | b;
        4'hD: r = b;
        4'hE: r = a & ~b;
        4'hF: r = ~b;
        default: r = s[31:0];
    endcase
    f_out[3] = r[31];
    f_out[2] = (r == 32'd0);
    f_out[1] = arith ? s[32] : f_in[1];
    f_out[0] = arith ? ((x[31] == y[31]) && (r[31] != x[31])) : f_in[0];
endtask

// Predicts the commit record and advances the model state
task automatic model_apply(input logic [31:0] w, output commit_t exp, output logic exec_known);
    logic [3:0]         rn;
    logic [3:0]         rd;
    logic [31:0]        a;
    logic [31:0]        b;
    logic [31:0]        r;
    logic [3:0]         nf;
    logic [31:0]        ea;
    logic [DMEM_AW-1:0] addr;
    logic               pass;
    exp        = '0;
    exp.pc     = m_pc;
    exp.next_pc = m_pc + 32'd1;
    exec_known = (w != 32'd0);
    rn   = w[19:16];
    rd   = w[15:12];
    a    = m_regs[rn];
    pass = (w != 32'd0) && (w[27:26] != 2'b11) && cond_holds(w[31:28], m_flags);
    exp.executed = pass;
    if (pass) begin
        case (w[27:26])
            2'b00: begin
                b = w[25] ? {24'd0, w[7:0]} : m_regs[w[3:0]];
                alu_model(w[24:21], a, b, m_flags, r, nf);
                if (w[20]) m_flags = nf;
                if (w[24:23] != 2'b10) begin        // Not a compare or test
                    exp.reg_write = 1'b1;
                    exp.rd        = rd;
                    exp.wdata     = r;
                    m_regs[rd]    = r;
                end
            end
            2'b01: begin
                ea   = a + {24'd0, w[7:0]};
                addr = ea[DMEM_AW-1:0];
                if (w[20]) begin
                    exp.reg_write = 1'b1;
                    exp.rd        = rd;
                    exp.wdata     = {24'd0, m_mem[addr]};
                    m_regs[rd]    = exp.wdata;
                end else begin
                    exp.mem_write = 1'b1;
                    exp.mem_addr  = {{(32-DMEM_AW){1'b0}}, addr};
                    exp.mem_wdata = m_regs[rd];
                    for (int k = 0; k < 4; k++) begin
                        m_mem[addr + DMEM_AW'(k)] = m_regs[rd][8*k +: 8];
                    end
                end
            end
            default: begin
                exp.next_pc = m_pc + 32'd1 + {{20{w[11]}}, w[11:0]};
            end
        endcase
    end
    exp.flags = m_flags;
    m_pc      = exp.next_pc;
endtask

`endif

// ==== tests/tb_arm_exec_core.sv ====
`default_nettype none

module tb_arm_exec_core;
    import arm_core_pkg::*;

    localparam int DMEM_AW    = 6;
    localparam int CLK_PERIOD = 40;
    localparam int N_NOP      = 6;
    localparam int N_DP       = 64;
    localparam int N_FLAGS    = 60;
    localparam int N_LDST     = 47;
    localparam int N_BR       = 48;
    localparam int N_HS       = 20;
    localparam int N_TOTAL    = N_NOP + N_DP + N_FLAGS + N_LDST + N_BR + N_HS;
    localparam longint WATCHDOG_TIME = longint'(N_TOTAL * 8 + N_TOTAL * 2 + 100) * CLK_PERIOD;

    logic    clk;
    logic    rst_n;
    logic    instr_req;
    word_t   instruction;
    logic    instr_ack;
    logic    commit_valid;
    commit_t commit;

    integer      seed;
    logic [31:0] rnd;
    int          errors;
    int          checks;
    int          tests_run;
    int          errors_at_start;
    int          checks_at_start;

    `include "tb_ref_model.svh"

    arm_exec_core #(
        .DMEM_AW (DMEM_AW)
    ) dut (
        .clk          (clk),
        .rst_n        (rst_n),
        .instr_req    (instr_req),
        .instruction  (instruction),
        .instr_ack    (instr_ack),
        .commit_valid (commit_valid),
        .commit       (commit)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    initial begin
        #(WATCHDOG_TIME);
        $display("Watchdog expired before all instructions were committed");
        $display("Simulation failed");
        $finish;
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        logic same;
        same = (got === exp);
        checks++;
        if (!same) begin
            errors++;
        end
        assert (same) else begin
            $display("[ERROR] t=%0t %s got 0x%08h expected 0x%08h", $time, name, got, exp);
        end
    endtask

    function automatic logic [31:0] dp_word(logic [3:0] cond, logic imm, logic [3:0] opc,
                                            logic s, logic [3:0] rn, logic [3:0] rd,
                                            logic [11:0] low);
        return {cond, 2'b00, imm, opc, s, rn, rd, low};
    endfunction

    function automatic logic [31:0] ls_word(logic [3:0] cond, logic load, logic [3:0] rn,
                                            logic [3:0] rd, logic [7:0] imm8);
        return {cond, 2'b01, 1'b1, 4'h0, load, rn, rd, 4'h0, imm8};
    endfunction

    function automatic logic [31:0] br_word(logic [3:0] cond, logic [11:0] off);
        return {cond, 2'b10, 14'd0, off};
    endfunction

    // One four-phase transfer with timing and commit checks
    task automatic run_instr(input logic [31:0] w);
        commit_t exp;
        commit_t got;
        logic    exec_known;
        logic    seen;
        int      n;
        model_apply(w, exp, exec_known);
        rnd = $random(seed);
        repeat (int'(rnd[0])) @(posedge clk);
        @(posedge clk);
        instr_req   <= 1'b1;
        instruction <= w;
        n    = 0;
        seen = 1'b0;
        while (n < 12 && !seen) begin
            @(posedge clk);
            n++;
            @(negedge clk);
            seen = instr_ack;
        end
        if (!seen) begin
            $display("No acknowledge within 12 cycles of request for 0x%08h", w);
            errors++;
        end
        check_value("instr_ack rise cycles", n, 32'd4);
        check_value("commit_valid", {31'd0, commit_valid}, 32'd1);
        got = commit;
        check_value("commit.pc", got.pc, exp.pc);
        if (exec_known) begin
            check_value("commit.executed", {31'd0, got.executed}, {31'd0, exp.executed});
        end
        check_value("commit.reg_write", {31'd0, got.reg_write}, {31'd0, exp.reg_write});
        if (exp.reg_write) begin
            check_value("commit.rd", {28'd0, got.rd}, {28'd0, exp.rd});
            check_value("commit.wdata", got.wdata, exp.wdata);
        end
        check_value("commit.mem_write", {31'd0, got.mem_write}, {31'd0, exp.mem_write});
        if (exp.mem_write) begin
            check_value("commit.mem_addr", got.mem_addr, exp.mem_addr);
            check_value("commit.mem_wdata", got.mem_wdata, exp.mem_wdata);
        end
        check_value("commit.next_pc", got.next_pc, exp.next_pc);
        check_value("commit.flags", {28'd0, got.flags}, {28'd0, exp.flags});
        @(posedge clk);
        instr_req <= 1'b0;
        @(negedge clk);
        check_value("commit_valid", {31'd0, commit_valid}, 32'd0);   // One-cycle pulse
        n    = 0;
        seen = 1'b0;
        while (n < 12 && !seen) begin
            @(posedge clk);
            n++;
            @(negedge clk);
            seen = !instr_ack;
        end
        if (!seen) begin
            $display("Acknowledge stayed high after the request was withdrawn");
            errors++;
        end
        check_value("instr_ack fall cycles", n, 32'd2);
    endtask

    task automatic start_test();
        errors_at_start = errors;
        checks_at_start = checks;
    endtask

    task automatic end_test(input string name);
        tests_run++;
        $display("%s: %s, %0d checks, %0d errors", name,
                 (errors == errors_at_start) ? "PASS" : "FAIL",
                 checks - checks_at_start, errors - errors_at_start);
    endtask

    initial begin
        logic [7:0] st_imm;
        logic [3:0] st_rn;
        logic [3:0] cond;
        clk         = 1'b0;
        rst_n       = 1'b0;
        instr_req   = 1'b0;
        instruction = '0;
        seed        = 59051;
        errors      = 0;
        checks      = 0;
        tests_run   = 0;
        model_reset();
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;

        start_test();
        @(negedge clk);
        check_value("instr_ack", {31'd0, instr_ack}, 32'd0);
        check_value("commit_valid", {31'd0, commit_valid}, 32'd0);
        run_instr(dp_word(4'hE, 1'b1, 4'hD, 1'b1, 4'h0, 4'h0, 12'd0));   // Sets Z for EQ
        for (int i = 0; i < N_NOP - 1; i++) begin
            run_instr(32'd0);
        end
        end_test("NOP and reset");

        start_test();
        for (int i = 0; i < 16; i++) begin
            rnd = $random(seed);
            run_instr(dp_word(4'hE, 1'b1, 4'hD, 1'b0, 4'h0, 4'(i), {4'h0, rnd[7:0]}));
        end
        for (int i = 0; i < N_DP - 16; i++) begin          // Every opcode three times
            rnd = $random(seed);
            run_instr(dp_word(4'hE, rnd[31], 4'(i), 1'b0, rnd[19:16], rnd[15:12], rnd[11:0]));
        end
        end_test("Data processing");

        start_test();
        for (int i = 0; i < N_FLAGS; i++) begin
            rnd = $random(seed);
            run_instr(dp_word(rnd[31:28], rnd[25], rnd[24:21], rnd[20] | rnd[21],
                              rnd[19:16], rnd[15:12], rnd[11:0]));
        end
        end_test("Flags and conditions");

        start_test();
        run_instr(dp_word(4'hE, 1'b1, 4'hD, 1'b0, 4'h0, 4'h2, 12'd0));
        run_instr(dp_word(4'hE, 1'b1, 4'hF, 1'b0, 4'h0, 4'h5, 12'h0A5));
        run_instr(ls_word(4'hE, 1'b0, 4'h2, 4'h5, 8'd62));  // Bytes 62, 63, 0, 1
        run_instr(ls_word(4'hE, 1'b1, 4'h2, 4'h6, 8'd62));
        run_instr(ls_word(4'hE, 1'b1, 4'h2, 4'h7, 8'd63));
        run_instr(ls_word(4'hE, 1'b1, 4'h2, 4'h8, 8'd64));
        run_instr(ls_word(4'hE, 1'b1, 4'h2, 4'h9, 8'd65));
        for (int i = 0; i < (N_LDST - 7) / 2; i++) begin
            rnd    = $random(seed);
            st_rn  = rnd[19:16];
            st_imm = rnd[7:0];
            run_instr(ls_word(4'hE, 1'b0, st_rn, rnd[15:12], st_imm));
            run_instr(ls_word(4'hE, 1'b1, st_rn, rnd[11:8], st_imm + {6'd0, rnd[25:24]}));
        end
        end_test("Load/store");

        start_test();
        for (int i = 0; i < N_BR / 2; i++) begin
            rnd = $random(seed);
            run_instr(dp_word(4'hE, rnd[25], 4'hA, 1'b1, rnd[19:16], 4'h0, rnd[11:0]));
            rnd  = $random(seed);
            cond = (rnd[31:28] == 4'hF) ? 4'hE : rnd[31:28];
            run_instr(br_word(cond, rnd[11:0]));
        end
        end_test("Branches");

        start_test();
        for (int i = 0; i < N_HS; i++) begin
            rnd = $random(seed);
            run_instr(dp_word(4'hE, rnd[25], rnd[24:21], rnd[20], rnd[19:16], rnd[15:12],
                              rnd[11:0]));
        end
        end_test("Handshake timing");

        $display("Tests: %0d, checks: %0d, errors: %0d", tests_run, checks, errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== hdl/arm_exec_core.sv ====
`default_nettype none

module arm_exec_core #(
    parameter int DMEM_AW = 6
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  instr_req,
    input  arm_core_pkg::word_t   instruction,
    output logic                  instr_ack,
    output logic                  commit_valid,
    output arm_core_pkg::commit_t commit
);
    import arm_core_pkg::*;

    typedef enum logic [1:0] {
        IDLE,
        EXEC,
        RESULT,
        ACK
    } state_t;

    state_t       state;
    logic         req_q;
    word_t        instr_q;
    ctrl_t        ctrl;
    reg_idx_t     rn_idx;
    reg_idx_t     rm_idx;
    word_t        rn_data;
    word_t        rm_data;
    flags_t       flags;
    exec_result_t exec_res;
    logic         rf_we;
    reg_idx_t     rf_waddr;
    word_t        rf_wdata;

    // Four-phase intake, one instruction in flight
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state        <= IDLE;
            req_q        <= 1'b0;
            commit_valid <= 1'b0;
        end else begin
            req_q        <= instr_req;         // Sampled request
            commit_valid <= (state == RESULT);
            case (state)
                IDLE:    if (req_q) state <= EXEC;
                EXEC:    state <= RESULT;
                RESULT:  state <= ACK;
                ACK:     if (!req_q) state <= IDLE;
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == IDLE && req_q) begin
            instr_q <= instruction;
        end
    end

    assign instr_ack = (state == ACK);

    control_unit u_control_unit (
        .instruction (instr_q),
        .ctrl        (ctrl)
    );

    execute_stage u_execute_stage (
        .clk     (clk),
        .rst_n   (rst_n),
        .start   (state == EXEC),
        .ctrl    (ctrl),
        .rn_data (rn_data),
        .rm_data (rm_data),
        .rn_idx  (rn_idx),
        .rm_idx  (rm_idx),
        .flags   (flags),
        .result  (exec_res)
    );

    register_file u_register_file (
        .clk     (clk),
        .rst_n   (rst_n),
        .raddr_a (rn_idx),
        .raddr_b (rm_idx),
        .rdata_a (rn_data),
        .rdata_b (rm_data),
        .we      (rf_we),
        .waddr   (rf_waddr),
        .wdata   (rf_wdata)
    );

    result_stage #(
        .DMEM_AW (DMEM_AW)
    ) u_result_stage (
        .clk       (clk),
        .rst_n     (rst_n),
        .commit_en (state == RESULT),
        .result    (exec_res),
        .flags     (flags),
        .rf_we     (rf_we),
        .rf_waddr  (rf_waddr),
        .rf_wdata  (rf_wdata),
        .commit    (commit)
    );

endmodule

`default_nettype wire

// ==== hdl/result_stage.sv ====
`default_nettype none

module result_stage #(
    parameter int DMEM_AW = 6
) (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       commit_en,
    input  arm_core_pkg::exec_result_t result,
    input  arm_core_pkg::flags_t       flags,
    output logic                       rf_we,
    output arm_core_pkg::reg_idx_t     rf_waddr,
    output arm_core_pkg::word_t        rf_wdata,
    output arm_core_pkg::commit_t      commit
);
    import arm_core_pkg::*;

    localparam int DMEM_BYTES = 2 ** DMEM_AW;

    logic [7:0]         dmem [DMEM_BYTES];
    logic [DMEM_AW-1:0] addr;
    word_t              pc;
    word_t              next_pc;
    word_t              branch_off;
    word_t              load_data;
    logic               is_load;
    logic               mem_write;

    assign addr      = result.alu_result[DMEM_AW-1:0];   // Wraps at memory size
    assign is_load   = result.mem_enable && !result.mem_rw;
    assign mem_write = result.mem_enable && result.mem_rw;

    // Little-endian, byte lanes wrap around the end
    always_comb begin
        load_data = '0;
        for (int i = 0; i < 4; i++) begin
            if (i == 0 || !result.mem_byte) begin
                load_data[8*i +: 8] = dmem[addr + DMEM_AW'(i)];
            end
        end
    end

    assign branch_off = {{20{result.br_offset[11]}}, result.br_offset};
    assign next_pc    = result.branch ? pc + 32'd1 + branch_off : pc + 32'd1;

    assign rf_we    = commit_en && result.reg_write;
    assign rf_waddr = result.rd;
    assign rf_wdata = is_load ? load_data : result.alu_result;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < DMEM_BYTES; i++) begin
                dmem[i] <= '0;
            end
        end else if (commit_en && mem_write) begin
            for (int i = 0; i < 4; i++) begin
                if (i == 0 || !result.mem_byte) begin
                    dmem[addr + DMEM_AW'(i)] <= result.store_data[8*i +: 8];
                end
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc     <= '0;
            commit <= '0;
        end else if (commit_en) begin
            pc               <= next_pc;
            commit.pc        <= pc;            // Address of this instruction
            commit.executed  <= result.executed;
            commit.reg_write <= result.reg_write;
            commit.rd        <= result.rd;
            commit.wdata     <= rf_wdata;
            commit.mem_write <= mem_write;
            commit.mem_addr  <= word_t'(addr);
            commit.mem_wdata <= result.store_data;
            commit.next_pc   <= next_pc;
            commit.flags     <= flags;         // Already updated by execute
        end
    end

endmodule

`default_nettype wire

// ==== hdl/register_file.sv ====
`default_nettype none

module register_file (
    input  logic                   clk,
    input  logic                   rst_n,
    input  arm_core_pkg::reg_idx_t raddr_a,
    input  arm_core_pkg::reg_idx_t raddr_b,
    output arm_core_pkg::word_t    rdata_a,
    output arm_core_pkg::word_t    rdata_b,
    input  logic                   we,
    input  arm_core_pkg::reg_idx_t waddr,
    input  arm_core_pkg::word_t    wdata
);
    import arm_core_pkg::*;

    word_t regs [16];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 16; i++) begin
                regs[i] <= '0;
            end
        end else if (we) begin
            regs[waddr] <= wdata;
        end
    end

    // Combinational read ports
    assign rdata_a = regs[raddr_a];
    assign rdata_b = regs[raddr_b];

endmodule

`default_nettype wire

// ==== hdl/execute_stage.sv ====
`default_nettype none

module execute_stage (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       start,
    input  arm_core_pkg::ctrl_t        ctrl,
    input  arm_core_pkg::word_t        rn_data,
    input  arm_core_pkg::word_t        rm_data,
    output arm_core_pkg::reg_idx_t     rn_idx,
    output arm_core_pkg::reg_idx_t     rm_idx,
    output arm_core_pkg::flags_t       flags,
    output arm_core_pkg::exec_result_t result
);
    import arm_core_pkg::*;

    word_t  op_b;
    word_t  alu_out;
    flags_t alu_flags;
    flags_t next_flags;
    logic   cond_pass;

    function automatic logic cond_check(cond_t cond, flags_t f);
        case (cond)
            COND_EQ: return f.z;
            COND_NE: return !f.z;
            COND_CS: return f.c;
            COND_CC: return !f.c;
            COND_MI: return f.n;
            COND_PL: return !f.n;
            COND_VS: return f.v;
            COND_VC: return !f.v;
            COND_HI: return f.c && !f.z;
            COND_LS: return !f.c || f.z;
            COND_GE: return f.n == f.v;
            COND_LT: return f.n != f.v;
            COND_GT: return !f.z && (f.n == f.v);
            COND_LE: return f.z || (f.n != f.v);
            COND_AL: return 1'b1;
            default: return 1'b0;        // NV, also decoded type 11
        endcase
    endfunction

    assign cond_pass = cond_check(ctrl.cond, flags);

    // Stores read Rd through the second port
    assign rn_idx = ctrl.rn;
    assign rm_idx = ctrl.mem_rw ? ctrl.rd : ctrl.rm;
    assign op_b   = ctrl.alu_src_imm ? {24'd0, ctrl.imm8} : rm_data;

    alu u_alu (
        .op       (ctrl.alu_op),
        .a        (rn_data),
        .b        (op_b),
        .carry_in (flags.c),
        .result   (alu_out),
        .flags    (alu_flags)
    );

    always_comb begin
        next_flags   = alu_flags;
        next_flags.v = is_arith_op(ctrl.alu_op) ? alu_flags.v : flags.v;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            result <= '0;
            flags  <= '0;
        end else if (start) begin
            result.executed   <= cond_pass;
            result.reg_write  <= cond_pass && ctrl.reg_write;
            result.rd         <= ctrl.rd;
            result.alu_result <= alu_out;
            result.store_data <= rm_data;
            result.mem_enable <= cond_pass && ctrl.mem_enable;
            result.mem_rw     <= ctrl.mem_rw;
            result.mem_byte   <= ctrl.mem_byte;
            result.branch     <= cond_pass && ctrl.branch;
            result.br_offset  <= ctrl.br_offset;
            if (cond_pass && ctrl.set_flags) begin
                flags <= next_flags;
            end
        end
    end

endmodule

`default_nettype wire

// ==== hdl/alu.sv ====
`default_nettype none

module alu (
    input  arm_core_pkg::alu_op_t op,
    input  arm_core_pkg::word_t   a,
    input  arm_core_pkg::word_t   b,
    input  logic                  carry_in,
    output arm_core_pkg::word_t   result,
    output arm_core_pkg::flags_t  flags
);
    import arm_core_pkg::*;

    word_t       add_x;
    word_t       add_y;
    logic        add_ci;
    logic [32:0] sum;

    // All six arithmetic ops share one adder
    always_comb begin
        add_x  = a;
        add_y  = b;
        add_ci = 1'b0;
        case (op)
            ALU_ADDC: begin
                add_ci = carry_in;
            end
            ALU_SUB: begin
                add_y  = ~b;
                add_ci = 1'b1;
            end
            ALU_SUBC: begin
                add_y  = ~b;
                add_ci = ~carry_in;          // Extra borrow when C set
            end
            ALU_RSUB: begin
                add_x  = b;
                add_y  = ~a;
                add_ci = 1'b1;
            end
            ALU_RSUBC: begin
                add_x  = b;
                add_y  = ~a;
                add_ci = ~carry_in;
            end
            default: begin
                add_ci = 1'b0;
            end
        endcase
    end

    assign sum = {1'b0, add_x} + {1'b0, add_y} + {32'd0, add_ci};

    always_comb begin
        case (op)
            ALU_AND:   result = a & b;
            ALU_OR:    result = a | b;
            ALU_XOR:   result = a ^ b;
            ALU_MOVA:  result = a;
            ALU_MOVB:  result = b;
            ALU_NOTB:  result = ~b;
            ALU_ANDNB: result = a & ~b;
            default:   result = sum[31:0];
        endcase
    end

    always_comb begin
        flags.n = result[31];
        flags.z = (result == '0);
        if (is_arith_op(op)) begin
            flags.c = sum[32];               // Inverted borrow on subtract
            flags.v = (add_x[31] == add_y[31]) && (sum[31] != add_x[31]);
        end else begin
            flags.c = carry_in;
            flags.v = 1'b0;                  // Flag register keeps V here
        end
    end

endmodule

`default_nettype wire

// ==== hdl/control_unit.sv ====
`default_nettype none

module control_unit (
    input  arm_core_pkg::word_t instruction,
    output arm_core_pkg::ctrl_t ctrl
);
    import arm_core_pkg::*;

    instr_type_t itype;
    dp_opcode_t  opcode;
    logic        imm_flag;
    logic        s_or_load;

    assign itype     = instr_type_t'(instruction[27:26]);
    assign opcode    = dp_opcode_t'(instruction[24:21]);
    assign imm_flag  = instruction[25];
    assign s_or_load = instruction[20];    // S bit, or L bit for memory ops

    function automatic alu_op_t map_alu_op(dp_opcode_t op);
        case (op)
            OP_AND:  return ALU_AND;
            OP_EOR:  return ALU_XOR;
            OP_SUB:  return ALU_SUB;
            OP_RSB:  return ALU_RSUB;
            OP_ADD:  return ALU_ADD;
            OP_ADC:  return ALU_ADDC;
            OP_SBC:  return ALU_SUBC;
            OP_RSC:  return ALU_RSUBC;
            OP_TST:  return ALU_AND;       // Flags only
            OP_TEQ:  return ALU_XOR;       // Flags only
            OP_CMP:  return ALU_SUB;       // Flags only
            OP_CMN:  return ALU_ADD;       // Flags only
            OP_ORR:  return ALU_OR;
            OP_MOV:  return ALU_MOVB;
            OP_BIC:  return ALU_ANDNB;
            OP_MVN:  return ALU_NOTB;
            default: return ALU_ADD;
        endcase
    endfunction

    always_comb begin
        ctrl           = '0;
        ctrl.cond      = cond_t'(instruction[31:28]);
        ctrl.rn        = instruction[19:16];
        ctrl.rd        = instruction[15:12];
        ctrl.rm        = instruction[3:0];
        ctrl.imm8      = instruction[7:0];
        ctrl.br_offset = instruction[11:0];
        ctrl.alu_op    = ALU_ADD;

        case (itype)
            DATA_PROC: begin
                ctrl.reg_write   = 1'b1;
                ctrl.alu_op      = map_alu_op(opcode);
                ctrl.set_flags   = s_or_load;
                ctrl.alu_src_imm = imm_flag;
                if (opcode inside {OP_TST, OP_TEQ, OP_CMP, OP_CMN}) begin
                    ctrl.reg_write = 1'b0;
                end
            end
            LOAD_STORE: begin
                ctrl.mem_enable  = 1'b1;
                ctrl.alu_src_imm = 1'b1;   // Rn + imm8 address
                if (s_or_load) begin
                    ctrl.reg_write  = 1'b1;
                    ctrl.mem_to_reg = 1'b1;
                    ctrl.mem_byte   = 1'b1;  // LDRB
                end else begin
                    ctrl.mem_rw = 1'b1;      // STR, full word
                end
            end
            BRANCH: begin
                ctrl.branch = 1'b1;
            end
            default: begin
                // Type 11 is never executed
                ctrl.cond = COND_NV;
            end
        endcase

        if (instruction == NOP_INSTR) begin
            ctrl = '0;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/arm_core_pkg.sv ====
`default_nettype none

package arm_core_pkg;

    typedef logic [31:0] word_t;
    typedef logic [3:0]  reg_idx_t;
    typedef logic [7:0]  imm8_t;
    typedef logic [11:0] br_offset_t;    // Signed word offset

    typedef enum logic [3:0] {
        ALU_ADD   = 4'b0000,             // A + B
        ALU_ADDC  = 4'b0001,             // A + B + C
        ALU_SUB   = 4'b0010,             // A - B
        ALU_SUBC  = 4'b0011,             // A - B - C
        ALU_RSUB  = 4'b0100,             // B - A
        ALU_RSUBC = 4'b0101,             // B - A - C
        ALU_AND   = 4'b0110,
        ALU_OR    = 4'b0111,
        ALU_XOR   = 4'b1000,
        ALU_MOVA  = 4'b1001,
        ALU_MOVB  = 4'b1010,
        ALU_NOTB  = 4'b1011,
        ALU_ANDNB = 4'b1100              // A and not B
    } alu_op_t;

    typedef enum logic [3:0] {
        OP_AND, OP_EOR, OP_SUB, OP_RSB, OP_ADD, OP_ADC, OP_SBC, OP_RSC,
        OP_TST, OP_TEQ, OP_CMP, OP_CMN, OP_ORR, OP_MOV, OP_BIC, OP_MVN
    } dp_opcode_t;

    typedef enum logic [1:0] {
        DATA_PROC  = 2'b00,
        LOAD_STORE = 2'b01,
        BRANCH     = 2'b10,
        UNUSED     = 2'b11
    } instr_type_t;

    typedef enum logic [3:0] {
        COND_EQ, COND_NE, COND_CS, COND_CC, COND_MI, COND_PL, COND_VS, COND_VC,
        COND_HI, COND_LS, COND_GE, COND_LT, COND_GT, COND_LE, COND_AL, COND_NV
    } cond_t;

    typedef struct packed {
        logic n;
        logic z;
        logic c;
        logic v;
    } flags_t;

    localparam word_t NOP_INSTR = '0;

    typedef struct packed {
        logic       reg_write;
        logic       mem_enable;
        logic       mem_rw;              // 1 for store
        logic       mem_to_reg;
        logic       alu_src_imm;
        logic       set_flags;
        alu_op_t    alu_op;
        logic       branch;
        logic       mem_byte;
        cond_t      cond;
        reg_idx_t   rn;
        reg_idx_t   rd;
        reg_idx_t   rm;
        imm8_t      imm8;
        br_offset_t br_offset;
    } ctrl_t;

    typedef struct packed {
        logic       executed;            // Condition passed
        logic       reg_write;
        reg_idx_t   rd;
        word_t      alu_result;
        word_t      store_data;
        logic       mem_enable;
        logic       mem_rw;
        logic       mem_byte;
        logic       branch;
        br_offset_t br_offset;
    } exec_result_t;

    typedef struct packed {
        word_t    pc;
        logic     executed;
        logic     reg_write;
        reg_idx_t rd;
        word_t    wdata;
        logic     mem_write;
        word_t    mem_addr;
        word_t    mem_wdata;
        word_t    next_pc;
        flags_t   flags;
    } commit_t;

    // Adder-based operations produce real C and V
    function automatic logic is_arith_op(alu_op_t op);
        return op inside {ALU_ADD, ALU_ADDC, ALU_SUB, ALU_SUBC, ALU_RSUB, ALU_RSUBC};
    endfunction

endpackage

`default_nettype wire
